// File: src/muldiv_pkg.sv
/* Widths, register map, control and status bit positions,
   opcode and controller state enums of the arithmetic coprocessor */
`default_nettype none

package muldiv_pkg;

    // ********************************************************
    // Widths
    // ********************************************************
    localparam int DATA_W = 16;             // Bus data, operand A, results
    localparam int OPB_W  = 8;              // Divisor and multiplier
    localparam int ADDR_W = 3;              // Word address
    localparam int OP_W   = 2;              // Opcode field in CTRL

    // ********************************************************
    // Register map
    // ********************************************************
    localparam logic [ADDR_W-1:0] REG_OPA  = 3'd0; // Dividend, or multiplicand in 7:0
    localparam logic [ADDR_W-1:0] REG_OPB  = 3'd1; // Divisor or multiplier
    localparam logic [ADDR_W-1:0] REG_CTRL = 3'd2; // Write command, read status
    localparam logic [ADDR_W-1:0] REG_RES  = 3'd3; // Quotient or product
    localparam logic [ADDR_W-1:0] REG_REM  = 3'd4; // Remainder

    // CTRL write fields
    localparam int CTRL_OP_LSB = 0;         // Opcode at 1:0
    localparam int CTRL_LEN    = 2;         // Long division
    localparam int CTRL_START  = 3;         // Launch

    // Status read bits
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_V    = 2;

    // Bit 1 selects the divider, bit 0 selects signed
    typedef enum logic [OP_W-1:0] {
        OP_MULU = 2'd0,
        OP_MULS = 2'd1,
        OP_DIVU = 2'd2,
        OP_DIVS = 2'd3
    } muldiv_op_e;

    // Command controller
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/muldiv_div.sv
/* Restoring divider, one quotient bit per clock, with signed mode,
   short (8 step) and long (16 step) mode and overflow flag */
`timescale 1ns/1ns
`default_nettype none

module muldiv_div (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,    // One cycle pulse
    input  wire                          len,      // Long mode
    input  wire                          sign,     // Signed operands
    input  wire  [muldiv_pkg::DATA_W-1:0] dividend,
    input  wire  [muldiv_pkg::OPB_W-1:0]  divisor,
    output logic [muldiv_pkg::DATA_W-1:0] quot,
    output logic [muldiv_pkg::DATA_W-1:0] rem,
    output logic                         busy,
    output logic                         v         // Zero divisor or overflow
);

    import muldiv_pkg::*;

    // Operand magnitudes, taken combinationally at start
    logic              a_neg;
    logic              b_neg;
    logic [DATA_W-1:0] a_mag;
    logic [OPB_W-1:0]  b_mag;

    // Iteration state
    logic [4:0]        cnt;       // Steps left minus one
    logic [OPB_W-1:0]  divor;     // Divisor magnitude
    logic [OPB_W-1:0]  pr;        // Partial remainder
    logic [DATA_W-1:0] dq;        // Dividend bits out at top, quotient bits in at bottom
    logic              q_neg;
    logic              r_neg;
    logic              dz;        // Divide by zero
    logic              ovf;       // Short mode quotient above 255

    // One step
    logic [OPB_W:0]    trial;
    logic [OPB_W:0]    diff;
    logic              ge;
    logic [DATA_W-1:0] q_mag;
    logic [OPB_W-1:0]  r_mag;
    logic              last;

    // Sign sits at bit 15 in long mode, at bit 7 in short mode
    // Short mode expects a sign extended byte in the upper half
    always_comb begin
        a_neg = sign & (len ? dividend[DATA_W-1] : dividend[OPB_W-1]);
        b_neg = sign & divisor[OPB_W-1];
        a_mag = a_neg ? -dividend : dividend;
        b_mag = b_neg ? -divisor : divisor;
    end

    assign trial = {pr, dq[DATA_W-1]};            // Bring down next dividend bit
    assign diff  = trial - {1'b0, divor};
    assign ge    = trial >= {1'b0, divor};        // Quotient bit
    assign q_mag = {dq[DATA_W-2:0], ge};
    assign r_mag = ge ? diff[OPB_W-1:0] : trial[OPB_W-1:0]; // Restore on miss
    assign last  = busy && (cnt == 5'd0);

    // ********************************************************
    // Control
    // ********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            cnt   <= 5'd0;
            q_neg <= 1'b0;
            r_neg <= 1'b0;
            dz    <= 1'b0;
            ovf   <= 1'b0;
            v     <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            cnt   <= len ? 5'd15 : 5'd7;
            q_neg <= a_neg ^ b_neg;               // Signs differ
            r_neg <= a_neg;                       // Remainder follows dividend
            dz    <= (b_mag == '0);
            // High byte not below divisor gives a 9-bit quotient
            ovf   <= !len && (a_mag[DATA_W-1:OPB_W] >= b_mag);
            v     <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 5'd1;
            if (last) begin
                busy <= 1'b0;                     // Falls with the results
                v    <= dz | ovf;
            end
        end
    end

    // ********************************************************
    // Datapath
    // ********************************************************
    always_ff @(posedge clk) begin
        if (start) begin
            divor <= b_mag;
            if (len) begin
                pr <= '0;
                dq <= a_mag;
            end else begin
                // Pre-aligned, high byte already in the remainder
                pr <= a_mag[DATA_W-1:OPB_W];
                dq <= {a_mag[OPB_W-1:0], {OPB_W{1'b0}}};
            end
        end else if (busy) begin
            pr <= r_mag;
            dq <= q_mag;
            if (last) begin
                quot <= q_neg ? -q_mag : q_mag;
                rem  <= r_neg ? -{{(DATA_W-OPB_W){1'b0}}, r_mag}
                              :  {{(DATA_W-OPB_W){1'b0}}, r_mag};
            end
        end
    end

endmodule

`default_nettype wire

// File: src/muldiv_mul.sv
/* Shift-and-add 8x8 multiplier, one multiplier bit per clock,
   with magnitude and sign handling for signed operands */
`timescale 1ns/1ns
`default_nettype none

module muldiv_mul (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,    // One cycle pulse
    input  wire                          sign,     // Signed operands
    input  wire  [muldiv_pkg::OPB_W-1:0]  mcand,
    input  wire  [muldiv_pkg::OPB_W-1:0]  mplier,
    output logic [muldiv_pkg::DATA_W-1:0] prod,
    output logic                         busy
);

    import muldiv_pkg::*;

    logic              mc_neg;
    logic              mp_neg;
    logic [OPB_W-1:0]  mc_mag;
    logic [OPB_W-1:0]  mp_mag;

    logic [2:0]        cnt;       // Steps left minus one
    logic              p_neg;     // Product sign
    logic [DATA_W-1:0] mc;        // Multiplicand, moves left each step
    logic [OPB_W-1:0]  mp;        // Multiplier, moves right each step
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] sum;

    always_comb begin
        mc_neg = sign & mcand[OPB_W-1];
        mp_neg = sign & mplier[OPB_W-1];
        mc_mag = mc_neg ? -mcand : mcand;         // -128 stays 0x80, read as 128
        mp_mag = mp_neg ? -mplier : mplier;
    end

    assign sum = acc + (mp[0] ? mc : '0);         // Add when the multiplier bit is set

    // Control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            cnt   <= 3'd0;
            p_neg <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            cnt   <= 3'd7;
            p_neg <= mc_neg ^ mp_neg;
        end else if (busy) begin
            cnt <= cnt - 3'd1;
            if (cnt == 3'd0) busy <= 1'b0;
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
            mc  <= {{(DATA_W-OPB_W){1'b0}}, mc_mag};
            mp  <= mp_mag;
        end else if (busy) begin
            acc <= sum;
            mc  <= {mc[DATA_W-2:0], 1'b0};
            mp  <= {1'b0, mp[OPB_W-1:1]};
            if (cnt == 3'd0) prod <= p_neg ? -sum : sum; // Last step
        end
    end

endmodule

`default_nettype wire

// File: src/muldiv_regs.sv
/* Wishbone classic register block with operand, command/status and result
   registers, and the controller that launches a unit and captures results */
`timescale 1ns/1ns
`default_nettype none

module muldiv_regs (
    input  wire                          clk,
    input  wire                          rst,
    // Wishbone classic slave
    input  wire                          cyc,
    input  wire                          stb,
    input  wire                          we,
    input  wire  [muldiv_pkg::ADDR_W-1:0] adr,
    input  wire  [muldiv_pkg::DATA_W-1:0] dat_w,
    output logic [muldiv_pkg::DATA_W-1:0] dat_r,
    output logic                         ack,
    output logic                         irq,      // Result unread
    // Divider
    output logic                         div_start,
    output logic                         div_len,
    output logic                         div_sign,
    output logic [muldiv_pkg::DATA_W-1:0] opa,
    output logic [muldiv_pkg::OPB_W-1:0]  opb,
    input  wire  [muldiv_pkg::DATA_W-1:0] div_quot,
    input  wire  [muldiv_pkg::DATA_W-1:0] div_rem,
    input  wire                          div_busy,
    input  wire                          div_v,
    // Multiplier
    output logic                         mul_start,
    output logic                         mul_sign,
    input  wire  [muldiv_pkg::DATA_W-1:0] mul_prod,
    input  wire                          mul_busy
);

    import muldiv_pkg::*;

    logic              access;    // New cycle, ack not yet given
    logic              wr;        // Write, taken on the edge closing ack
    logic              rd;
    ctrl_state_e       state;
    muldiv_op_e        op_q;      // Running opcode
    muldiv_op_e        cmd_op;    // Opcode on the bus
    logic              launch;
    logic              unit_busy;
    logic              pending;   // Start pulse still in flight
    logic [DATA_W-1:0] res_q;
    logic [DATA_W-1:0] rem_q;
    logic              v_q;
    logic [DATA_W-1:0] status;

    assign access    = cyc && stb && !ack;
    assign wr        = cyc && stb && we && ack;
    assign rd        = cyc && stb && !we && ack;
    assign cmd_op    = muldiv_op_e'(dat_w[CTRL_OP_LSB +: OP_W]);
    // START is dropped while a unit runs
    assign launch    = wr && (adr == REG_CTRL) && dat_w[CTRL_START] && (state != ST_RUN);
    assign unit_busy = (op_q inside {OP_DIVU, OP_DIVS}) ? div_busy : mul_busy;
    assign pending   = div_start || mul_start;

    always_comb begin
        status            = '0;
        status[STAT_BUSY] = (state == ST_RUN);    // Covers the launch cycle too
        status[STAT_DONE] = (state == ST_DONE);
        status[STAT_V]    = v_q;
    end

    // ********************************************************
    // Bus side: ack, read mux, operand registers
    // ********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            dat_r <= '0;
            opa   <= '0;
            opb   <= '0;
        end else begin
            ack <= access;                        // One cycle, then one low at least
            if (access) begin
                case (adr)
                    REG_OPA:  dat_r <= opa;
                    REG_OPB:  dat_r <= {{(DATA_W-OPB_W){1'b0}}, opb};
                    REG_CTRL: dat_r <= status;
                    REG_RES:  dat_r <= res_q;
                    REG_REM:  dat_r <= rem_q;
                    default:  dat_r <= '0;
                endcase
            end
            if (wr && adr == REG_OPA) opa <= dat_w;              // Units latched theirs
            if (wr && adr == REG_OPB) opb <= dat_w[OPB_W-1:0];
        end
    end

    // ********************************************************
    // Command controller
    // ********************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            op_q      <= OP_MULU;
            div_start <= 1'b0;
            div_len   <= 1'b0;
            div_sign  <= 1'b0;
            mul_start <= 1'b0;
            mul_sign  <= 1'b0;
            res_q     <= '0;
            rem_q     <= '0;
            v_q       <= 1'b0;
            irq       <= 1'b0;
        end else begin
            div_start <= 1'b0;                    // Pulses
            mul_start <= 1'b0;
            if (rd && adr == REG_CTRL) irq <= 1'b0; // Status read acknowledges
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (launch) begin
                        op_q  <= cmd_op;
                        state <= ST_RUN;
                        irq   <= 1'b0;
                        v_q   <= 1'b0;
                        case (cmd_op)
                            OP_MULU, OP_MULS: begin
                                mul_start <= 1'b1;
                                mul_sign  <= (cmd_op == OP_MULS);
                            end
                            default: begin
                                div_start <= 1'b1;
                                div_sign  <= (cmd_op == OP_DIVS);
                                div_len   <= dat_w[CTRL_LEN];
                            end
                        endcase
                    end
                end
                ST_RUN: begin
                    // Unit busy rises the cycle after start, so skip the pulse cycle
                    if (!pending && !unit_busy) begin
                        state <= ST_DONE;
                        irq   <= 1'b1;
                        if (op_q inside {OP_DIVU, OP_DIVS}) begin
                            res_q <= div_quot;
                            rem_q <= div_rem;
                            v_q   <= div_v;
                        end else begin
                            res_q <= mul_prod;
                            rem_q <= '0;
                            v_q   <= 1'b0;            // Product never overflows
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/muldiv_top.sv
/* Coprocessor top: register block, divider and multiplier */
`timescale 1ns/1ns
`default_nettype none

module muldiv_top (
    input  wire                          clk,
    input  wire                          rst,
    // Wishbone classic slave
    input  wire                          cyc,
    input  wire                          stb,
    input  wire                          we,
    input  wire  [muldiv_pkg::ADDR_W-1:0] adr,
    input  wire  [muldiv_pkg::DATA_W-1:0] dat_w,
    output logic [muldiv_pkg::DATA_W-1:0] dat_r,
    output logic                         ack,
    output logic                         irq
);

    import muldiv_pkg::*;

    // Operands, shared by both units
    logic [DATA_W-1:0] opa;
    logic [OPB_W-1:0]  opb;

    // Divider handshake
    logic              div_start;
    logic              div_len;
    logic              div_sign;
    logic [DATA_W-1:0] div_quot;
    logic [DATA_W-1:0] div_rem;
    logic              div_busy;
    logic              div_v;

    // Multiplier handshake
    logic              mul_start;
    logic              mul_sign;
    logic [DATA_W-1:0] mul_prod;
    logic              mul_busy;

    muldiv_regs i_muldiv_regs (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .irq       (irq),
        .div_start (div_start),
        .div_len   (div_len),
        .div_sign  (div_sign),
        .opa       (opa),
        .opb       (opb),
        .div_quot  (div_quot),
        .div_rem   (div_rem),
        .div_busy  (div_busy),
        .div_v     (div_v),
        .mul_start (mul_start),
        .mul_sign  (mul_sign),
        .mul_prod  (mul_prod),
        .mul_busy  (mul_busy)
    );

    muldiv_div i_muldiv_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .len      (div_len),
        .sign     (div_sign),
        .dividend (opa),
        .divisor  (opb),
        .quot     (div_quot),
        .rem      (div_rem),
        .busy     (div_busy),
        .v        (div_v)
    );

    // Multiplicand is the low byte of operand A
    muldiv_mul i_muldiv_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .sign   (mul_sign),
        .mcand  (opa[OPB_W-1:0]),
        .mplier (opb),
        .prod   (mul_prod),
        .busy   (mul_busy)
    );

endmodule

`default_nettype wire

// File: verification/muldiv_sva.sv
/* Bus and unit handshake assertions, bound into the register block */
`timescale 1ns/1ns
`default_nettype none

module muldiv_sva (
    input wire                          clk,
    input wire                          rst,
    input wire                          cyc,
    input wire                          stb,
    input wire                          ack,
    input wire                          irq,
    input wire                          div_start,
    input wire                          mul_start,
    input wire                          div_busy,
    input wire                          mul_busy,
    input wire muldiv_pkg::ctrl_state_e state
);

    import muldiv_pkg::*;

    // ********************************************************
    // Wishbone side
    // ********************************************************
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack stayed high for more than one cycle");

    ack_with_request: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
        else $error("ack without an active bus cycle");

    // Unit handshake
    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        (div_start || mul_start) |-> !(div_busy || mul_busy))
        else $error("start pulse while a unit is busy");

    // Controller must not finish while a unit still works
    busy_in_run: assert property (@(posedge clk) disable iff (rst)
        (div_busy || mul_busy) |-> state == ST_RUN)
        else $error("unit busy outside the run state");

    irq_after_reset: assert property (@(posedge clk) $fell(rst) |-> !irq)
        else $error("irq high right after reset");    // No result yet

endmodule

bind muldiv_regs muldiv_sva i_muldiv_sva (
    .clk       (clk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .ack       (ack),
    .irq       (irq),
    .div_start (div_start),
    .mul_start (mul_start),
    .div_busy  (div_busy),
    .mul_busy  (mul_busy),
    .state     (state)
);

`default_nettype wire

// File: verification/muldiv_tb.sv
/* Directed testbench for the coprocessor: Wishbone bus model, reference
   arithmetic model, checks and the test tasks */
`timescale 1ns/1ns
`default_nettype none

module muldiv_tb;

    import muldiv_pkg::*;

    localparam int ACK_TIMEOUT = 8;         // Cycles to wait for ack
    localparam int POLL_LIMIT  = 40;        // Status reads before giving up
    localparam int IRQ_TIMEOUT = 100;       // Cycles to wait for irq

    logic              clk;
    logic              rst;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;
    logic              irq;

    int seed = 386;                         // Random operand stream

    muldiv_top i_muldiv_top (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .irq   (irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    // ********************************************************
    // Error handling and checks
    // ********************************************************
    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected 0x%04h actual 0x%04h", name, exp, act);
            stop_on_error();
        end
    endtask

    // ********************************************************
    // Wishbone classic master
    // ********************************************************
    task automatic bus_cycle(input logic write, input logic [ADDR_W-1:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int n;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        n     = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < ACK_TIMEOUT);
        if (!ack) begin
            $display("Bus access to register %0d got no ack", addr);
            stop_on_error();
        end else begin
            rdata = dat_r;                  // Valid while ack is high
            @(negedge clk);                 // Hold through the ack edge
            cyc = 1'b0;
            stb = 1'b0;
            we  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
        logic [15:0] ignored;
        bus_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] addr, output logic [15:0] data);
        bus_cycle(1'b0, addr, 16'h0000, data);
    endtask

    // CTRL word with START set
    function automatic logic [15:0] command(input muldiv_op_e op, input logic len);
        logic [15:0] cmd;
        cmd                      = '0;
        cmd[CTRL_OP_LSB +: OP_W] = op;
        cmd[CTRL_LEN]            = len;
        cmd[CTRL_START]          = 1'b1;
        return cmd;
    endfunction

    // Load operands, launch, poll until not busy, fetch results
    task automatic run_op(input muldiv_op_e op, input logic len, input logic [15:0] a,
                          input logic [7:0] b, output logic [15:0] res,
                          output logic [15:0] rem, output logic [15:0] stat);
        int polls;
        wb_write(REG_OPA, a);
        wb_write(REG_OPB, {8'h00, b});
        wb_write(REG_CTRL, command(op, len));
        polls = 0;
        stat  = 16'h0001;                   // Busy until the first poll says otherwise
        while (stat[STAT_BUSY] && polls < POLL_LIMIT) begin
            wb_read(REG_CTRL, stat);
            polls++;
        end
        if (stat[STAT_BUSY]) begin
            $display("Unit still busy after %0d status reads", polls);
            stop_on_error();
        end else begin
            wb_read(REG_RES, res);
            wb_read(REG_REM, rem);
        end
    endtask

    // ********************************************************
    // Reference arithmetic
    // ********************************************************
    task automatic ref_model(input muldiv_op_e op, input logic len, input logic [15:0] a,
                             input logic [7:0] b, output logic [15:0] res,
                             output logic [15:0] rem, output logic v);
        int x;
        int y;
        int q;
        int r;
        bit sgn;
        bit neg_x;
        bit neg_y;
        sgn = (op == OP_MULS) || (op == OP_DIVS);
        res = '0;
        rem = '0;
        v   = 1'b0;
        if (sgn) y = int'($signed(b));
        else     y = int'(b);
        if (op == OP_MULU || op == OP_MULS) begin
            if (sgn) x = int'($signed(a[7:0]));  // Multiplicand is the low byte
            else     x = int'(a[7:0]);
            q   = x * y;
            res = q[15:0];
        end else begin
            if (!sgn)    x = int'(a);            // Short unsigned divides the whole word
            else if (len) x = int'($signed(a));  // Sign at bit 15
            else          x = int'($signed(a[7:0])); // Sign at bit 7
            neg_x = (x < 0);
            neg_y = (y < 0);
            if (neg_x) x = -x;
            if (neg_y) y = -y;
            if (y == 0) begin
                v = 1'b1;
            end else begin
                q = x / y;
                r = x % y;
                v = !len && (q > 255);
                if (neg_x != neg_y) q = -q;
                if (neg_x) r = -r;               // Remainder follows the dividend
                res = q[15:0];
                rem = r[15:0];
            end
        end
    endtask

    // One operation against the model, results only when V is clear
    task automatic check_op(input string name, input muldiv_op_e op, input logic len,
                            input logic [15:0] a, input logic [7:0] b);
        logic [15:0] res;
        logic [15:0] rem;
        logic [15:0] stat;
        logic [15:0] exp_res;
        logic [15:0] exp_rem;
        logic        exp_v;
        run_op(op, len, a, b, res, rem, stat);
        ref_model(op, len, a, b, exp_res, exp_rem, exp_v);
        check_eq({name, " V"}, {15'h0, exp_v}, {15'h0, stat[STAT_V]});
        if (!exp_v) begin
            check_eq({name, " result"}, exp_res, res);
            check_eq({name, " remainder"}, exp_rem, rem);
        end
    endtask

    // ********************************************************
    // Tests
    // ********************************************************
    task automatic test_reset();
        logic [15:0] rd;
        check_eq("reset irq", 16'h0, {15'h0, irq});
        wb_read(REG_CTRL, rd);
        check_eq("reset status", 16'h0, rd);
        wb_read(REG_RES, rd);
        check_eq("reset result", 16'h0, rd);
        wb_write(REG_OPA, 16'hA5C3);
        wb_read(REG_OPA, rd);
        check_eq("opa readback", 16'hA5C3, rd);
        wb_write(REG_OPB, 16'h3C7E);
        wb_read(REG_OPB, rd);
        check_eq("opb readback", 16'h007E, rd);     // Only 8 bits stored
    endtask

    task automatic test_div_unsigned();
        int a;
        int b;
        repeat (6) begin
            b = 1 + (($random(seed) & 32'h7fffffff) % 255);   // Never zero
            a = $random(seed) & 32'h0000ffff;
            check_op("divu long", OP_DIVU, 1'b1, a[15:0], b[7:0]);
            a = ($random(seed) & 32'h7fffffff) % (b * 256);   // Quotient below 256
            check_op("divu short", OP_DIVU, 1'b0, a[15:0], b[7:0]);
        end
        check_op("divu short 255", OP_DIVU, 1'b0, 16'h09FF, 8'h0A);
    endtask

    task automatic test_div_signed();
        int mode;
        int combo;
        int ma;
        int mb;
        int sa;
        int sb;
        for (mode = 0; mode < 2; mode++) begin
            for (combo = 0; combo < 4; combo++) begin
                mb = 1 + (($random(seed) & 32'h7fffffff) % 127);
                if (mode == 1) ma = 1 + (($random(seed) & 32'h7fffffff) % 32767);
                else           ma = 1 + (($random(seed) & 32'h7fffffff) % 127);
                sa = combo[1] ? -ma : ma;
                sb = combo[0] ? -mb : mb;
                check_op(mode == 1 ? "divs long" : "divs short", OP_DIVS, mode[0],
                         sa[15:0], sb[7:0]);      // Short dividend arrives sign extended
            end
        end
        check_op("divs short -128/-1", OP_DIVS, 1'b0, 16'hFF80, 8'hFF);
        check_op("divs short -7/2", OP_DIVS, 1'b0, 16'hFFF9, 8'h02);
        check_op("divs long -7/2", OP_DIVS, 1'b1, 16'hFFF9, 8'h02);
    endtask

    task automatic test_mul();
        logic [7:0] edges [3];
        int i;
        int j;
        int a;
        int b;
        edges[0] = 8'h00;
        edges[1] = 8'hFF;
        edges[2] = 8'h80;                   // -128 when signed
        for (i = 0; i < 3; i++) begin
            for (j = 0; j < 3; j++) begin
                check_op("mulu edge", OP_MULU, 1'b0, {8'h00, edges[i]}, edges[j]);
                check_op("muls edge", OP_MULS, 1'b0, {8'h00, edges[i]}, edges[j]);
            end
        end
        repeat (6) begin
            a = $random(seed);              // High byte must be ignored
            b = $random(seed);
            check_op("mulu random", OP_MULU, 1'b0, a[15:0], b[7:0]);
            check_op("muls random", OP_MULS, 1'b0, a[15:0], b[7:0]);
        end
    endtask

    task automatic test_overflow();
        check_op("divu long zero", OP_DIVU, 1'b1, 16'h1234, 8'h00);
        check_op("divs short zero", OP_DIVS, 1'b0, 16'hFFF0, 8'h00);
        check_op("divu short 256", OP_DIVU, 1'b0, 16'h0A00, 8'h0A);
        check_op("divu short big", OP_DIVU, 1'b0, 16'h1234, 8'h10);
    endtask

    // A second START during a long division is dropped
    task automatic test_irq_and_busy();
        logic [15:0] rd;
        int n;
        wb_write(REG_OPA, 16'd1000);
        wb_write(REG_OPB, 16'd10);
        wb_write(REG_CTRL, command(OP_DIVU, 1'b1));
        check_eq("irq while running", 16'h0, {15'h0, irq});
        wb_write(REG_OPA, 16'h0077);
        wb_write(REG_OPB, 16'h0003);
        wb_write(REG_CTRL, command(OP_MULU, 1'b0));
        n = 0;
        while (!irq && n < IRQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("irq did not rise within %0d cycles of the division", IRQ_TIMEOUT);
            stop_on_error();
        end else begin
            wb_read(REG_RES, rd);
            check_eq("busy start result", 16'd100, rd);
            wb_read(REG_REM, rd);
            check_eq("busy start remainder", 16'd0, rd);
            check_eq("irq until status read", 16'h1, {15'h0, irq});
            wb_read(REG_CTRL, rd);
            check_eq("status when done", 16'h0002, rd);   // DONE only
            check_eq("irq after status read", 16'h0, {15'h0, irq});
        end
    endtask

    // ********************************************************
    // Sequence
    // ********************************************************
    initial begin
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_div_unsigned();
        test_div_signed();
        test_mul();
        test_overflow();
        test_irq_and_busy();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/muldiv_pkg.sv
src/muldiv_div.sv
src/muldiv_mul.sv
src/muldiv_regs.sv
src/muldiv_top.sv
verification/muldiv_sva.sv
verification/muldiv_tb.sv

// File: Makefile
# Verilator lint, simulation and cleanup for the arithmetic coprocessor

TOP := muldiv_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module muldiv_top -f sources.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
